/* verilog/lane_seq_pkg.sv */
package lane_seq_pkg;

   ////////////////////////////////////////
   // Sizes
   localparam int LANE_NUM        = 8;
   localparam int MEM_DEPTH       = 512;
   localparam int ADDR_W          = $clog2(MEM_DEPTH);
   localparam int MAX_VL_PER_LANE = 256;
   localparam int VL_W            = $clog2(LANE_NUM * MAX_VL_PER_LANE) + 1; // Holds the full count
   localparam int CNT_W           = $clog2(MAX_VL_PER_LANE) + 1;

   ////////////////////////////////////////
   // Encodings
   typedef enum logic [1:0] {
      NORMAL = 2'd0,
      STORE  = 2'd1,
      LOAD   = 2'd2
   } inst_type_e;

   typedef enum logic [1:0] {
      SEW_8  = 2'd0,
      SEW_16 = 2'd1,
      SEW_32 = 2'd2
   } sew_e;

   typedef enum logic [1:0] {
      IDLE       = 2'd0,
      RUN_NORMAL = 2'd1,
      RUN_STORE  = 2'd2,
      RUN_LOAD   = 2'd3
   } seq_state_e;

   ////////////////////////////////////////
   // Bundles
   typedef struct packed {
      logic [1:0]  op2_sel;
      logic [2:0]  op3_sel;
      logic [31:0] x_data;
      logic [4:0]  imm;
      logic [5:0]  opmode;
   } alu_ctrl_s;

   typedef struct packed {
      inst_type_e                             inst_type;
      sew_e                                   sew;
      logic [VL_W-1:0]                        vl;
      logic [$clog2(MAX_VL_PER_LANE)-1:0]     inst_delay;  // Operand read to result write
      logic [ADDR_W-1:0]                      start_waddr;
      logic [1:0][ADDR_W-1:0]                 start_raddr;
      logic                                   vector_mask;
      alu_ctrl_s                              alu;
   } vseq_cmd_s;

   typedef struct packed {
      logic                   en;
      logic [1:0][ADDR_W-1:0] raddr;
      sew_e                   sew;
   } vrf_rd_s;

   typedef struct packed {
      logic                     en;
      logic [ADDR_W-1:0]        addr;
      logic [LANE_NUM-1:0][3:0] bwen;  // One nibble per lane
   } vrf_wr_s;

endpackage

/* verilog/vreg_addr_counter.sv */
`timescale 1ns/10ps

module vreg_addr_counter import lane_seq_pkg::*; (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic [ADDR_W-1:0] start_addr_i,
   input  logic              load_i,
   input  logic              step_i,
   input  sew_e              sew_i,
   output logic [ADDR_W-1:0] addr_o
);

   logic [ADDR_W-1:0] addr_q;
   logic [1:0]        elem_q;     // Elements already passed in this word
   logic [1:0]        last_elem;

   // Elements per word minus one
   always_comb begin
      case (sew_i)
         SEW_8:   last_elem = 2'd3;
         SEW_16:  last_elem = 2'd1;
         default: last_elem = 2'd0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         addr_q <= '0;
         elem_q <= '0;
      end
      else if (load_i) begin
         addr_q <= start_addr_i;
         elem_q <= '0;
      end
      else if (step_i) begin
         if (elem_q == last_elem) begin  // Word complete
            addr_q <= addr_q + 1'b1;
            elem_q <= '0;
         end
         else begin
            elem_q <= elem_q + 1'b1;
         end
      end
   end

   assign addr_o = addr_q;

   // Stepping off the top of the lane memory would land on word 0
   a_no_wrap: assert property (@(posedge clk_i) disable iff (!rst_i)
      (step_i && !load_i && elem_q == last_elem) |-> (addr_q != ADDR_W'(MEM_DEPTH - 1)))
      else $error("vreg_addr_counter: address wrapped past MEM_DEPTH");

endmodule

/* verilog/byte_enable_gen.sv */
`timescale 1ns/10ps

module byte_enable_gen import lane_seq_pkg::*; (
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     run_i,
   input  sew_e                     sew_i,
   output logic [LANE_NUM-1:0][3:0] bwen_o
);

   logic [3:0] shift4_q;  // Byte position, one-hot
   logic [1:0] shift2_q;  // Halfword position
   logic [3:0] pattern;

   ////////////////////////////////////////
   // Rotation registers
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         shift4_q <= 4'b0001;
         shift2_q <= 2'b01;
      end
      else if (run_i) begin
         shift4_q <= {shift4_q[2:0], shift4_q[3]};
         shift2_q <= {shift2_q[0], shift2_q[1]};
      end
      else begin
         // Idle cycle, next run starts at element 0
         shift4_q <= 4'b0001;
         shift2_q <= 2'b01;
      end
   end

   ////////////////////////////////////////
   // Pattern select
   always_comb begin
      case (sew_i)
         SEW_8:   pattern = shift4_q;
         SEW_16:  pattern = {{2{shift2_q[1]}}, {2{shift2_q[0]}}};
         SEW_32:  pattern = 4'b1111;
         default: pattern = 4'b0000;
      endcase
   end

   assign bwen_o = {LANE_NUM{pattern}};  // Same pattern in every lane

endmodule

/* verilog/lane_valid_tracker.sv */
`timescale 1ns/10ps

module lane_valid_tracker import lane_seq_pkg::*; (
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic [VL_W-1:0]     vl_i,
   input  logic                load_i,
   input  logic                step_i,
   output logic [LANE_NUM-1:0] valid_o
);

   logic [VL_W-1:0] remain_q;  // Elements not yet covered by a read word

   ////////////////////////////////////////
   // Remaining element count
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         remain_q <= '0;
      end
      else if (load_i) begin
         remain_q <= vl_i;
      end
      else if (step_i) begin
         // Floor at zero so idle cycles show no valid lane
         if (remain_q > VL_W'(LANE_NUM)) begin
            remain_q <= remain_q - VL_W'(LANE_NUM);
         end
         else begin
            remain_q <= '0;
         end
      end
   end

   ////////////////////////////////////////
   // Lane mask
   always_comb begin
      for (int i = 0; i < LANE_NUM; i++) begin
         valid_o[i] = (remain_q > VL_W'(i));  // Lane i holds element 8k + i
      end
   end

endmodule

/* verilog/lane_seq_ctrl.sv */
`timescale 1ns/10ps

module lane_seq_ctrl import lane_seq_pkg::*; (
   input  logic                               clk_i,
   input  logic                               rst_i,
   input  logic                               start_i,
   input  vseq_cmd_s                          cmd_i,
   input  logic                               load_last_i,
   input  logic [LANE_NUM-1:0][3:0]           load_bwen_i,
   input  logic [LANE_NUM-1:0][3:0]           wr_bwen_i,
   input  logic [1:0][ADDR_W-1:0]             raddr_i,
   input  logic [ADDR_W-1:0]                  waddr_i,
   output logic                               ready_o,
   output logic                               ready_for_load_o,
   output logic                               cnt_load_o,
   output logic                               rd_step_o,
   output logic                               wr_step_o,
   output sew_e                               rd_sew_o,
   output sew_e                               wr_sew_o,
   output logic                               pattern_run_o,
   output logic                               valid_load_o,
   output logic                               valid_step_o,
   output vrf_rd_s                            vrf_rd_o,
   output vrf_wr_s                            vrf_wr_o,
   output logic [$clog2(MAX_VL_PER_LANE)-1:0] vmrf_addr_o,
   output logic                               vmrf_wen_o,
   output logic                               store_data_valid_o,
   output alu_ctrl_s                          alu_o
);

   localparam int LANE_SH = $clog2(LANE_NUM);

   seq_state_e                         state;
   vseq_cmd_s                          cmd_q;
   logic                               accept;
   logic [VL_W:0]                      vl_sum;
   logic [VL_W:0]                      w_full;
   logic [CNT_W-1:0]                   w_in;          // Read limit of the incoming command
   logic [CNT_W:0]                     limit_sum_in;
   logic [CNT_W-1:0]                   read_limit_q;
   logic [CNT_W:0]                     limit_sum_q;   // Delay plus read limit
   logic [CNT_W-1:0]                   main_cnt;
   logic [CNT_W:0]                     next_cnt;
   logic [$clog2(MAX_VL_PER_LANE)-1:0] vmrf_cnt;
   logic                               rd_en_q;
   logic                               wr_en_q;
   sew_e                               rd_sew_q;
   sew_e                               wr_sew_q;
   logic                               rd_more;
   logic                               wr_window;

   ////////////////////////////////////////
   // Read limit, ceil(vl / LANE_NUM)
   assign accept       = start_i && ready_o;
   assign vl_sum       = {1'b0, cmd_i.vl} + (VL_W + 1)'(LANE_NUM - 1);
   assign w_full       = vl_sum >> LANE_SH;
   assign w_in         = w_full[CNT_W-1:0];
   assign limit_sum_in = (CNT_W + 1)'(cmd_i.inst_delay) + (CNT_W + 1)'(w_in);

   assign next_cnt  = {1'b0, main_cnt} + 1'b1;                    // Cycle index of the next cycle
   assign rd_more   = next_cnt < (CNT_W + 1)'(read_limit_q);
   assign wr_window = (next_cnt >= (CNT_W + 1)'(cmd_q.inst_delay)) && (next_cnt < limit_sum_q);

   // Instruction register
   always_ff @(posedge clk_i) begin
      if (accept) begin
         cmd_q        <= cmd_i;
         read_limit_q <= w_in;
         limit_sum_q  <= limit_sum_in;
      end
   end

   ////////////////////////////////////////
   // FSM and counters
   always_ff @(posedge clk_i) begin
      if (!rst_i) begin
         state    <= IDLE;
         ready_o  <= 1'b1;
         rd_en_q  <= 1'b0;
         wr_en_q  <= 1'b0;
         main_cnt <= '0;
         vmrf_cnt <= '0;
         rd_sew_q <= SEW_32;
         wr_sew_q <= SEW_32;
      end
      else if (accept) begin
         main_cnt <= '0;
         vmrf_cnt <= '0;
         ready_o  <= 1'b0;
         rd_sew_q <= cmd_i.sew;
         wr_sew_q <= cmd_i.sew;
         case (cmd_i.inst_type)
            NORMAL: begin
               state   <= RUN_NORMAL;
               rd_en_q <= (w_in != '0);
               wr_en_q <= (w_in != '0) && (cmd_i.inst_delay == '0);  // Zero delay writes at once
            end
            STORE: begin
               state    <= RUN_STORE;
               rd_en_q  <= (w_in != '0);
               rd_sew_q <= SEW_32;     // Store data moves whole words
            end
            LOAD: begin
               state    <= RUN_LOAD;
               wr_en_q  <= 1'b1;
               wr_sew_q <= SEW_32;     // One word per beat
            end
            default: begin
               ready_o <= 1'b1;        // Unknown type is dropped
            end
         endcase
      end
      else begin
         if (state != IDLE) begin
            main_cnt <= main_cnt + 1'b1;
         end
         if (wr_en_q && state == RUN_NORMAL) begin
            vmrf_cnt <= vmrf_cnt + 1'b1;
         end
         case (state)
            RUN_NORMAL: begin
               rd_en_q <= rd_more;
               wr_en_q <= wr_window;
               if (next_cnt >= limit_sum_q) begin  // Last write done
                  state   <= IDLE;
                  ready_o <= 1'b1;
               end
            end
            RUN_STORE: begin
               rd_en_q <= rd_more;
               if (!rd_more) begin
                  state   <= IDLE;
                  ready_o <= 1'b1;
               end
            end
            RUN_LOAD: begin
               if (load_last_i) begin  // Load unit ends the sequence
                  wr_en_q <= 1'b0;
                  state   <= IDLE;
                  ready_o <= 1'b1;
               end
            end
            default: begin
               rd_en_q <= 1'b0;
               wr_en_q <= 1'b0;
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // Counter and generator controls
   assign cnt_load_o    = accept;
   assign rd_step_o     = rd_en_q;
   assign wr_step_o     = wr_en_q;
   assign rd_sew_o      = rd_sew_q;
   assign wr_sew_o      = wr_sew_q;
   assign pattern_run_o = wr_en_q && (state == RUN_NORMAL);
   assign valid_load_o  = accept && (cmd_i.inst_type != LOAD);  // Loads read nothing
   assign valid_step_o  = rd_en_q;

   // Port outputs
   assign vrf_rd_o.en    = rd_en_q;
   assign vrf_rd_o.raddr = raddr_i;
   assign vrf_rd_o.sew   = rd_sew_q;

   assign vrf_wr_o.en   = wr_en_q;
   assign vrf_wr_o.addr = waddr_i;
   assign vrf_wr_o.bwen = (state == RUN_LOAD) ? load_bwen_i : wr_bwen_i;

   assign ready_for_load_o   = wr_en_q && (state == RUN_LOAD);
   assign store_data_valid_o = rd_en_q && (state == RUN_STORE);
   assign vmrf_addr_o        = vmrf_cnt;
   assign vmrf_wen_o         = wr_en_q && cmd_q.vector_mask;
   assign alu_o              = cmd_q.alu;

   ////////////////////////////////////////
   // Checks
   a_ready_no_write: assert property (@(posedge clk_i) disable iff (!rst_i)
      !(ready_o && vrf_wr_o.en))
      else $error("lane_seq_ctrl: write enable high while ready");

   // Ready only while no instruction runs
   a_idle_ready: assert property (@(posedge clk_i) disable iff (!rst_i)
      (state == IDLE) == ready_o)
      else $error("lane_seq_ctrl: ready_o out of step with the state");

endmodule

/* verilog/lane_seq_top.sv */
`timescale 1ns/10ps

module lane_seq_top import lane_seq_pkg::*; (
   input  logic                               clk_i,
   input  logic                               rst_i,
   input  logic                               start_i,
   input  vseq_cmd_s                          cmd_i,
   output logic                               ready_o,
   input  logic [LANE_NUM-1:0][3:0]           load_bwen_i,
   input  logic                               load_last_i,
   output logic                               ready_for_load_o,
   output vrf_rd_s                            vrf_rd_o,
   output vrf_wr_s                            vrf_wr_o,
   output logic [$clog2(MAX_VL_PER_LANE)-1:0] vmrf_addr_o,
   output logic                               vmrf_wen_o,
   output logic [LANE_NUM-1:0]                read_data_valid_o,
   output logic                               store_data_valid_o,
   output alu_ctrl_s                          alu_o
);

   logic                     cnt_load;
   logic                     rd_step;
   logic                     wr_step;
   sew_e                     rd_sew;
   sew_e                     wr_sew;
   logic                     pattern_run;
   logic                     valid_load;
   logic                     valid_step;
   logic [1:0][ADDR_W-1:0]   raddr;
   logic [ADDR_W-1:0]        waddr;
   logic [LANE_NUM-1:0][3:0] wr_bwen;

   lane_seq_ctrl u_ctrl (
      .clk_i              (clk_i),
      .rst_i              (rst_i),
      .start_i            (start_i),
      .cmd_i              (cmd_i),
      .load_last_i        (load_last_i),
      .load_bwen_i        (load_bwen_i),
      .wr_bwen_i          (wr_bwen),
      .raddr_i            (raddr),
      .waddr_i            (waddr),
      .ready_o            (ready_o),
      .ready_for_load_o   (ready_for_load_o),
      .cnt_load_o         (cnt_load),
      .rd_step_o          (rd_step),
      .wr_step_o          (wr_step),
      .rd_sew_o           (rd_sew),
      .wr_sew_o           (wr_sew),
      .pattern_run_o      (pattern_run),
      .valid_load_o       (valid_load),
      .valid_step_o       (valid_step),
      .vrf_rd_o           (vrf_rd_o),
      .vrf_wr_o           (vrf_wr_o),
      .vmrf_addr_o        (vmrf_addr_o),
      .vmrf_wen_o         (vmrf_wen_o),
      .store_data_valid_o (store_data_valid_o),
      .alu_o              (alu_o)
   );

   ////////////////////////////////////////
   // Address counters
   vreg_addr_counter u_waddr_cnt (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .start_addr_i (cmd_i.start_waddr),
      .load_i       (cnt_load),
      .step_i       (wr_step),
      .sew_i        (wr_sew),
      .addr_o       (waddr)
   );

   for (genvar i = 0; i < 2; i++) begin : g_raddr  // One per source operand
      vreg_addr_counter u_raddr_cnt (
         .clk_i        (clk_i),
         .rst_i        (rst_i),
         .start_addr_i (cmd_i.start_raddr[i]),
         .load_i       (cnt_load),
         .step_i       (rd_step),
         .sew_i        (rd_sew),
         .addr_o       (raddr[i])
      );
   end

   ////////////////////////////////////////
   // Byte enables and lane valid
   byte_enable_gen u_bwen_gen (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .run_i  (pattern_run),
      .sew_i  (wr_sew),
      .bwen_o (wr_bwen)
   );

   lane_valid_tracker u_valid (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .vl_i    (cmd_i.vl),
      .load_i  (valid_load),
      .step_i  (valid_step),
      .valid_o (read_data_valid_o)
   );

endmodule

/* testbench/lane_seq_model.svh */
// One enabled VRF cycle, counted from the first cycle after acceptance
typedef struct packed {
   logic [9:0]          cyc;
   logic [ADDR_W-1:0]   raddr0;
   logic [ADDR_W-1:0]   raddr1;
   sew_e                sew;
   logic [LANE_NUM-1:0] valid;
} rd_rec_s;

typedef struct packed {
   logic [9:0]               cyc;
   logic [ADDR_W-1:0]        addr;
   logic [LANE_NUM-1:0][3:0] bwen;
   logic [7:0]               maddr;
} wr_rec_s;

logic [LANE_NUM-1:0][3:0] load_beats[32];  // Byte enables of each load beat
rd_rec_s                  exp_rd[$];
wr_rec_s                  exp_wr[$];
int                       exp_end;         // Cycle in which ready_o returns

function automatic int elems_per_word(sew_e sew);
   case (sew)
      SEW_8:   return 4;
      SEW_16:  return 2;
      default: return 1;
   endcase
endfunction

function automatic logic [3:0] lane_pattern(sew_e sew, int k);
   case (sew)
      SEW_8:   return 4'(1 << (k % 4));
      SEW_16:  return (k % 2 == 0) ? 4'b0011 : 4'b1100;
      default: return 4'b1111;
   endcase
endfunction

// Lane i of read word k carries element k * LANE_NUM + i
function automatic logic [LANE_NUM-1:0] lane_valid(int vl, int k);
   logic [LANE_NUM-1:0] v;
   for (int i = 0; i < LANE_NUM; i++) begin
      v[i] = (k * LANE_NUM + i < vl);
   end
   return v;
endfunction

// Expected read enable in a given cycle of the current instruction
function automatic logic read_due(int cyc);
   for (int i = 0; i < exp_rd.size(); i++) begin
      if (int'(exp_rd[i].cyc) == cyc) begin
         return 1'b1;
      end
   end
   return 1'b0;
endfunction

// Expected write enable in a given cycle of the current instruction
function automatic logic write_due(int cyc);
   for (int i = 0; i < exp_wr.size(); i++) begin
      if (int'(exp_wr[i].cyc) == cyc) begin
         return 1'b1;
      end
   end
   return 1'b0;
endfunction

task automatic build_expected(input vseq_cmd_s cmd, input int n_beats);
   rd_rec_s r;
   wr_rec_s w;
   int      vl;
   int      w_lim;
   int      delay;
   sew_e    rsew;
   vl    = int'(cmd.vl);
   w_lim = (vl + LANE_NUM - 1) / LANE_NUM;
   delay = int'(cmd.inst_delay);
   rsew  = (cmd.inst_type == STORE) ? SEW_32 : cmd.sew;  // Stores read whole words
   exp_rd.delete();
   exp_wr.delete();
   if (cmd.inst_type != LOAD) begin
      for (int k = 0; k < w_lim; k++) begin
         r.cyc    = 10'(k);
         r.raddr0 = cmd.start_raddr[0] + ADDR_W'(k / elems_per_word(rsew));
         r.raddr1 = cmd.start_raddr[1] + ADDR_W'(k / elems_per_word(rsew));
         r.sew    = rsew;
         r.valid  = lane_valid(vl, k);
         exp_rd.push_back(r);
      end
   end
   if (cmd.inst_type == NORMAL) begin
      for (int k = 0; k < w_lim; k++) begin
         w.cyc   = 10'(delay + k);
         w.addr  = cmd.start_waddr + ADDR_W'(k / elems_per_word(cmd.sew));
         w.bwen  = {LANE_NUM{lane_pattern(cmd.sew, k)}};
         w.maddr = 8'(k);
         exp_wr.push_back(w);
      end
      exp_end = delay + w_lim;
   end
   else if (cmd.inst_type == STORE) begin
      exp_end = w_lim;
   end
   else begin
      for (int k = 0; k < n_beats; k++) begin  // One word per beat
         w.cyc   = 10'(k);
         w.addr  = cmd.start_waddr + ADDR_W'(k);
         w.bwen  = load_beats[k];
         w.maddr = 8'd0;
         exp_wr.push_back(w);
      end
      exp_end = n_beats;
   end
endtask

/* testbench/lane_seq_tb.sv */
`timescale 1ns/10ps

module lane_seq_tb import lane_seq_pkg::*; ();

   localparam int NUM_CMDS    = 200;
   localparam int CMD_TIMEOUT = 600;  // Cycles allowed per wait
   localparam int MAX_BEATS   = 24;

   logic                               clk_i;
   logic                               rst_i;
   logic                               start_i;
   vseq_cmd_s                          cmd_i;
   logic                               ready_o;
   logic [LANE_NUM-1:0][3:0]           load_bwen_i;
   logic                               load_last_i;
   logic                               ready_for_load_o;
   vrf_rd_s                            vrf_rd_o;
   vrf_wr_s                            vrf_wr_o;
   logic [$clog2(MAX_VL_PER_LANE)-1:0] vmrf_addr_o;
   logic                               vmrf_wen_o;
   logic [LANE_NUM-1:0]                read_data_valid_o;
   logic                               store_data_valid_o;
   alu_ctrl_s                          alu_o;

   `include "lane_seq_model.svh"

   rd_rec_s act_rd[$];
   wr_rec_s act_wr[$];
   int      errors;
   logic    timed_out;

   lane_seq_top UUT (.*);

   initial clk_i = 1'b0;
   always #50 clk_i = ~clk_i;

   task automatic report_mismatch(input string name, input logic [63:0] exp,
                                  input logic [63:0] act);
      errors++;
      $display("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, act);
   endtask

   function automatic vseq_cmd_s random_cmd();
      vseq_cmd_s c;
      c.inst_type      = inst_type_e'(2'($urandom_range(0, 2)));
      c.sew            = sew_e'(2'($urandom_range(0, 2)));
      c.vl             = VL_W'($urandom_range(1, 256));
      c.inst_delay     = 8'($urandom_range(0, 12));
      c.start_waddr    = ADDR_W'($urandom_range(0, 400));  // Room for the longest run
      c.start_raddr[0] = ADDR_W'($urandom_range(0, 400));
      c.start_raddr[1] = ADDR_W'($urandom_range(0, 400));
      c.vector_mask    = 1'($urandom_range(0, 1));
      c.alu            = 48'({$urandom, $urandom});
      return c;
   endfunction

   ////////////////////////////////////////
   // Record comparison
   task automatic compare_records();
      if (act_rd.size() != exp_rd.size())
         report_mismatch("read cycle count", 64'(exp_rd.size()), 64'(act_rd.size()));
      for (int i = 0; i < exp_rd.size() && i < act_rd.size(); i++) begin
         if (act_rd[i].cyc !== exp_rd[i].cyc)
            report_mismatch("vrf_rd_o.en cycle", 64'(exp_rd[i].cyc), 64'(act_rd[i].cyc));
         if (act_rd[i].raddr0 !== exp_rd[i].raddr0)
            report_mismatch("vrf_rd_o.raddr[0]", 64'(exp_rd[i].raddr0), 64'(act_rd[i].raddr0));
         if (act_rd[i].raddr1 !== exp_rd[i].raddr1)
            report_mismatch("vrf_rd_o.raddr[1]", 64'(exp_rd[i].raddr1), 64'(act_rd[i].raddr1));
         if (act_rd[i].sew !== exp_rd[i].sew)
            report_mismatch("vrf_rd_o.sew", 64'(exp_rd[i].sew), 64'(act_rd[i].sew));
         if (act_rd[i].valid !== exp_rd[i].valid)
            report_mismatch("read_data_valid_o", 64'(exp_rd[i].valid), 64'(act_rd[i].valid));
      end
      if (act_wr.size() != exp_wr.size())
         report_mismatch("write cycle count", 64'(exp_wr.size()), 64'(act_wr.size()));
      for (int i = 0; i < exp_wr.size() && i < act_wr.size(); i++) begin
         if (act_wr[i].cyc !== exp_wr[i].cyc)
            report_mismatch("vrf_wr_o.en cycle", 64'(exp_wr[i].cyc), 64'(act_wr[i].cyc));
         if (act_wr[i].addr !== exp_wr[i].addr)
            report_mismatch("vrf_wr_o.addr", 64'(exp_wr[i].addr), 64'(act_wr[i].addr));
         if (act_wr[i].bwen !== exp_wr[i].bwen)
            report_mismatch("vrf_wr_o.bwen", 64'(exp_wr[i].bwen), 64'(act_wr[i].bwen));
         if (act_wr[i].maddr !== exp_wr[i].maddr)
            report_mismatch("vmrf_addr_o", 64'(exp_wr[i].maddr), 64'(act_wr[i].maddr));
      end
   endtask

   ////////////////////////////////////////
   // One instruction from handshake to ready
   task automatic run_command(input vseq_cmd_s cmd, input int n_beats);
      int      cyc;
      logic    done;
      logic    exp_ren;
      logic    exp_wen;
      logic    exp_flag;
      rd_rec_s r;
      wr_rec_s w;
      cyc  = 0;
      done = 1'b0;
      while (!ready_o && cyc < CMD_TIMEOUT) begin
         @(posedge clk_i);
         #1;
         cyc++;
      end
      if (!ready_o) begin
         errors++;
         timed_out = 1'b1;
         $display("Timeout: ready_o stayed low before a new command at %0t", $time);
         return;
      end
      build_expected(cmd, n_beats);
      act_rd.delete();
      act_wr.delete();
      start_i = 1'b1;
      cmd_i   = cmd;
      @(posedge clk_i);
      #1;
      start_i = 1'b0;
      cmd_i   = random_cmd();  // Must be ignored while busy
      cyc     = 0;
      while (!done && cyc < CMD_TIMEOUT) begin
         load_last_i = (cmd.inst_type == LOAD) && (cyc == n_beats - 1);
         load_bwen_i = (cyc < n_beats) ? load_beats[cyc] : 32'($urandom);
         @(negedge clk_i);
         if (cyc == 0 && ready_o !== 1'b0)
            report_mismatch("ready_o", 64'd0, 64'(ready_o));
         if (cyc > 0 && ready_o) begin
            done = 1'b1;
            if (cyc != exp_end)
               report_mismatch("ready_o return cycle", 64'(exp_end), 64'(cyc));
         end
         else begin
            exp_ren = read_due(cyc);
            exp_wen = write_due(cyc);
            if (alu_o !== cmd.alu)
               report_mismatch("alu_o", 64'(cmd.alu), 64'(alu_o));
            exp_flag = exp_wen & cmd.vector_mask;
            if (vmrf_wen_o !== exp_flag)
               report_mismatch("vmrf_wen_o", 64'(exp_flag), 64'(vmrf_wen_o));
            exp_flag = exp_wen & (cmd.inst_type == LOAD);
            if (ready_for_load_o !== exp_flag)
               report_mismatch("ready_for_load_o", 64'(exp_flag), 64'(ready_for_load_o));
            exp_flag = exp_ren & (cmd.inst_type == STORE);
            if (store_data_valid_o !== exp_flag)
               report_mismatch("store_data_valid_o", 64'(exp_flag),
                               64'(store_data_valid_o));
            if (vrf_rd_o.en) begin
               r.cyc    = 10'(cyc);
               r.raddr0 = vrf_rd_o.raddr[0];
               r.raddr1 = vrf_rd_o.raddr[1];
               r.sew    = vrf_rd_o.sew;
               r.valid  = read_data_valid_o;
               act_rd.push_back(r);
            end
            if (vrf_wr_o.en) begin
               w.cyc   = 10'(cyc);
               w.addr  = vrf_wr_o.addr;
               w.bwen  = vrf_wr_o.bwen;
               w.maddr = vmrf_addr_o;
               act_wr.push_back(w);
            end
         end
         @(posedge clk_i);
         #1;
         cyc++;
      end
      if (!done) begin
         errors++;
         timed_out = 1'b1;
         $display("Timeout: instruction never returned ready_o at %0t", $time);
      end
      else begin
         compare_records();
      end
   endtask

   ////////////////////////////////////////
   // Main sequence
   initial begin
      vseq_cmd_s cmd;
      int        n_beats;
      void'($urandom(33837));
      errors      = 0;
      timed_out   = 1'b0;
      rst_i       = 1'b0;
      start_i     = 1'b0;
      cmd_i       = '0;
      load_bwen_i = '0;
      load_last_i = 1'b0;
      repeat (2) @(posedge clk_i);
      #1;
      rst_i = 1'b1;
      @(negedge clk_i);
      if (ready_o !== 1'b1) report_mismatch("ready_o", 64'd1, 64'(ready_o));
      if (vrf_rd_o.en !== 1'b0) report_mismatch("vrf_rd_o.en", 64'd0, 64'(vrf_rd_o.en));
      if (vrf_wr_o.en !== 1'b0) report_mismatch("vrf_wr_o.en", 64'd0, 64'(vrf_wr_o.en));
      if (store_data_valid_o !== 1'b0)
         report_mismatch("store_data_valid_o", 64'd0, 64'(store_data_valid_o));
      if (ready_for_load_o !== 1'b0)
         report_mismatch("ready_for_load_o", 64'd0, 64'(ready_for_load_o));
      if (vmrf_wen_o !== 1'b0) report_mismatch("vmrf_wen_o", 64'd0, 64'(vmrf_wen_o));
      @(posedge clk_i);
      #1;
      for (int n = 0; n < NUM_CMDS && !timed_out; n++) begin
         cmd     = random_cmd();
         n_beats = (cmd.inst_type == LOAD) ? int'($urandom_range(1, MAX_BEATS)) : 0;
         for (int b = 0; b < n_beats; b++) begin
            load_beats[b] = 32'($urandom);
         end
         run_command(cmd, n_beats);
      end
      $display("Errors: %0d after %0d commands", errors, NUM_CMDS);
      if (errors == 0) begin
         $display("All checks passed");
      end
      else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

/* sim.f */
+incdir+testbench
verilog/lane_seq_pkg.sv
verilog/vreg_addr_counter.sv
verilog/byte_enable_gen.sv
verilog/lane_valid_tracker.sv
verilog/lane_seq_ctrl.sv
verilog/lane_seq_top.sv
testbench/lane_seq_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module lane_seq_tb -o lane_seq_sim \
   || { echo "Build failed"; exit 1; }
out=$(./obj_dir/lane_seq_sim)
echo "$out"
echo "$out" | grep -qx "All checks passed" && exit 0 || exit 1
